// File: bench/sonar_patterns.hex
// per burst: sample count (hex), then the samples oldest first as 12-bit two's
// complement with the trigger sample last, then the expected lag index
// a count of 000 ends the file
017 000 000 000 000 000 000 000 000 000 000 064
064 064 F9C F9C F9C 064 F9C 000 000 000 000 3E8
005
017 000 000 000 078 078 078 F88 F88 F88 078 F88
000 032 032 032 FCE FCE FCE 032 FCE 000 000 4B0
00C
017 E48 E5C E70 E84 E98 EAC EC0 ED4 EE8 EFC F10
F24 F38 F4C F60 F74 F88 F9C FB0 FC4 FD8 FEC 3E8
001
017 000 000 064 064 064 F9C F9C F9C 064 F9C 000
064 064 064 F9C F9C F9C 064 F9C 000 000 000 3E8
004
017 05A 05A 05A FA6 FA6 FA6 05A FA6 000 000 000
000 000 000 000 000 000 000 000 000 000 000 44C
00F
017 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 B50
000
000

// File: vlog.f
+incdir+hw
hw/sonar_data_pkg.sv
hw/sonar_ctrl_pkg.sv
hw/general_counter.sv
hw/pipeline_controller.sv
hw/sample_ring_buffer.sv
hw/cross_correlator.sv
hw/uart_tx.sv
hw/sonar_top.sv
bench/sonar_checker.sv
bench/tb_sonar.sv

// File: run_sim.sh
#!/bin/sh
# build the sonar testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_sonar -f vlog.f \
    --Mdir obj_dir -o sim_sonar
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_sonar)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "All tests passed"; then
    exit 0
fi
exit 1

// File: bench/tb_sonar.sv
// testbench top: clock, reset, pattern file reader,
// four-phase sample driver and run limit
`timescale 1ns/1ps
`default_nettype none

`include "sonar_consts.svh"

module tb_sonar;
    import sonar_data_pkg::*;

    localparam int pat_depth = 512;

    logic        clk = 1'b0;
    logic        reset_b;
    logic        sample_req;
    sample_t     sample_data;
    logic        sample_ack;
    logic        rs_tx;
    logic        busy;
    logic        expect_valid;
    logic [7:0]  expect_burst;
    lag_t        expect_index;
    int          reports_seen;
    int          pass_count;
    int          error_count;
    logic [11:0] pat_mem [pat_depth];  // count, samples oldest first, expected index
    integer      seed;
    int          cycles = 0;
    int          cycle_limit = 0;      // 0 until the patterns are read

    always #50 clk = ~clk;             // 100 ns period

    sonar_top i_dut (
        .clk         (clk),
        .reset_b     (reset_b),
        .sample_req  (sample_req),
        .sample_data (sample_data),
        .sample_ack  (sample_ack),
        .rs_tx       (rs_tx),
        .busy        (busy)
    );

    sonar_checker i_check (
        .clk          (clk),
        .reset_b      (reset_b),
        .sample_req   (sample_req),
        .sample_ack   (sample_ack),
        .rs_tx        (rs_tx),
        .busy         (busy),
        .expect_valid (expect_valid),
        .expect_burst (expect_burst),
        .expect_index (expect_index),
        .reports_seen (reports_seen),
        .pass_count   (pass_count),
        .error_count  (error_count)
    );

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles, reports still missing", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    // hand one expected index to the checker, one cycle wide
    task automatic post_expected(input logic [7:0] burst, input lag_t index);
        expect_burst = burst;
        expect_index = index;
        expect_valid = 1'b1;
        @(negedge clk);
        expect_valid = 1'b0;
    endtask

    // four-phase req/ack, then a random idle gap
    task automatic send_sample(input sample_t value);
        int gap;
        sample_data = value;
        sample_req  = 1'b1;
        do @(negedge clk); while (!sample_ack);   // waits out back-pressure
        sample_req = 1'b0;
        do @(negedge clk); while (sample_ack);
        gap = $random(seed) & 3;
        repeat (gap) @(negedge clk);
    endtask

    initial begin
        int ptr;
        int n;
        int bursts;
        reset_b      = 1'b0;
        sample_req   = 1'b0;
        sample_data  = '0;
        expect_valid = 1'b0;
        expect_burst = '0;
        expect_index = '0;
        seed         = 32'h8547;
        $readmemh("bench/sonar_patterns.hex", pat_mem);

        // walk the bursts, budget each one
        ptr    = 0;
        bursts = 0;
        while (ptr < pat_depth && pat_mem[ptr] != 12'h000) begin
            n = int'(pat_mem[ptr]);
            cycle_limit += n * 8 + 200 + `SONAR_HOLDOFF;
            bursts++;
            ptr += n + 2;
        end

        repeat (5) @(posedge clk);
        @(negedge clk);
        reset_b = 1'b1;

        ptr = 0;
        for (int b = 0; b < bursts; b++) begin
            n = int'(pat_mem[ptr]);
            post_expected(b[7:0], pat_mem[ptr + n + 1][7:0]);
            for (int i = 1; i <= n; i++) send_sample(sample_t'(pat_mem[ptr + i]));
            ptr += n + 2;
        end

        while (reports_seen < bursts) @(negedge clk);
        repeat (`SONAR_HOLDOFF + 20) @(negedge clk);  // room for a stray byte

        $display("%0d bursts, %0d reports, %0d passed, %0d errors",
                 bursts, reports_seen, pass_count, error_count);
        if (bursts > 0 && error_count == 0 && pass_count == bursts) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/sonar_checker.sv
// testbench watcher: four-phase order, back-pressure, uart frame decode
// and comparison of each reported lag index against the pattern file
`timescale 1ns/1ps
`default_nettype none

`include "sonar_consts.svh"

module sonar_checker (
    input  wire logic                 clk,
    input  wire logic                 reset_b,
    input  wire logic                 sample_req,
    input  wire logic                 sample_ack,
    input  wire logic                 rs_tx,
    input  wire logic                 busy,
    input  wire logic                 expect_valid,  // one cycle per burst
    input  wire logic [7:0]           expect_burst,
    input  wire sonar_data_pkg::lag_t expect_index,
    output int                        reports_seen,
    output int                        pass_count,
    output int                        error_count
);
    import sonar_data_pkg::*;

    localparam int bd = `SONAR_BAUD_DIV;

    int   exp_burst_q[$];                  // pending bursts, oldest first
    lag_t exp_index_q[$];
    logic req_at_edge = 1'b0;              // req as the dut saw it
    logic ack_prev = 1'b0;
    logic rs_prev = 1'b1;
    logic busy_prev = 1'b0;
    logic in_frame = 1'b0;
    lag_t rx_byte = '0;
    int   pos = 0;                         // negedges since start bit seen
    int   holdoff_left = 0;
    int   errors = 0;
    int   passes = 0;
    int   reports = 0;

    task automatic score_report(input lag_t got);
        int   burst;
        lag_t want;
        reports++;
        if (exp_index_q.size() == 0) begin
            $display("uart byte %0d arrived with no report expected", got);
            errors++;
        end else begin
            burst = exp_burst_q.pop_front();
            want  = exp_index_q.pop_front();
            if (got === want) begin
                $display("burst_%0d: index %0d ok", burst, got);
                passes++;
            end else begin
                $display("Error: burst_%0d expected %0d, actual %0d", burst, want, got);
                errors++;
            end
        end
    endtask

    always @(posedge clk) begin
        req_at_edge = sample_req;          // stable here, driven on negedge
        if (expect_valid) begin
            exp_burst_q.push_back(int'(expect_burst));
            exp_index_q.push_back(expect_index);
        end
    end

    always @(negedge clk) begin
        if (!reset_b) begin
            if (rs_tx !== 1'b1 || busy !== 1'b0 || sample_ack !== 1'b0) begin
                $display("reset values wrong: rs_tx %b, busy %b, sample_ack %b",
                         rs_tx, busy, sample_ack);
                errors++;
            end
            in_frame     = 1'b0;
            holdoff_left = 0;
        end else begin
            // four-phase order
            if (sample_ack && !ack_prev && !req_at_edge) begin
                $display("sample_ack rose while sample_req was low");
                errors++;
            end
            if (!sample_ack && ack_prev && req_at_edge) begin
                $display("sample_ack fell while sample_req was still high");
                errors++;
            end
            // intake must stay closed while busy and through the hold-off
            if (sample_ack && !ack_prev && (busy || holdoff_left > 0)) begin
                $display("sample acked while busy or during the hold-off");
                errors++;
            end
            if (busy_prev && !busy) holdoff_left = `SONAR_HOLDOFF;
            else if (holdoff_left > 0) holdoff_left--;

            if (!in_frame) begin
                if (rs_prev && !rs_tx) begin   // start bit edge
                    in_frame = 1'b1;
                    pos      = 0;
                    if (!busy) begin
                        $display("uart start bit sent while busy was low");
                        errors++;
                    end
                end
            end else begin
                pos++;
                if (rs_tx != rs_prev && pos % bd != 0) begin
                    $display("uart line changed in the middle of a bit");
                    errors++;
                end
                if (pos == bd / 2 && rs_tx) begin
                    $display("uart start bit not low at mid-bit");
                    errors++;
                end
                if (pos > bd && pos < 9 * bd && pos % bd == bd / 2)
                    rx_byte = {rs_tx, rx_byte[7:1]};  // lsb arrives first
                if (pos == 9 * bd + bd / 2) begin     // mid stop bit
                    in_frame = 1'b0;
                    if (!rs_tx) begin
                        $display("uart stop bit not high");
                        errors++;
                    end
                    if (busy) begin
                        $display("busy still high during the stop bit");
                        errors++;
                    end
                    score_report(rx_byte);
                end
            end
        end
        ack_prev  = sample_ack;
        rs_prev   = rs_tx;
        busy_prev = busy;
        reports_seen <= reports;           // tb reads these on later negedges
        pass_count   <= passes;
        error_count  <= errors;
    end

endmodule

`default_nettype wire

// File: hw/sonar_top.sv
// top level: ring buffer, correlator, controller, uart tx
`timescale 1ns/1ps
`default_nettype none

module sonar_top (
    input  wire logic                     clk,
    input  wire logic                     reset_b,
    input  wire logic                     sample_req,
    input  wire sonar_data_pkg::sample_t  sample_data,
    output logic                          sample_ack,
    output logic                          rs_tx,
    output logic                          busy         // capture in flight
);
    import sonar_data_pkg::*;

    logic     trigger, spi_en;
    logic     start_cc, cc_done;
    logic     tx_ready, tx_write_en;
    buf_off_t rd_off;
    sample_t  rd_data;
    lag_t     max_index;

    sample_ring_buffer i_buf (
        .clk         (clk),
        .reset_b     (reset_b),
        .sample_req  (sample_req),
        .sample_data (sample_data),
        .sample_ack  (sample_ack),
        .spi_en      (spi_en),
        .trigger     (trigger),
        .rd_off      (rd_off),
        .rd_data     (rd_data)
    );

    cross_correlator i_cc (
        .clk       (clk),
        .reset_b   (reset_b),
        .start_cc  (start_cc),
        .rd_off    (rd_off),
        .rd_data   (rd_data),
        .cc_done   (cc_done),
        .max_index (max_index)
    );

    pipeline_controller i_ctrl (
        .clk                (clk),
        .reset_b            (reset_b),
        .trigger            (trigger),
        .cc_done            (cc_done),
        .tx_ready           (tx_ready),
        .rs_tx              (rs_tx),
        .trigger_persistent (busy),
        .start_cc           (start_cc),
        .tx_write_en        (tx_write_en),
        .spi_en             (spi_en)
    );

    uart_tx i_tx (
        .clk         (clk),
        .reset_b     (reset_b),
        .tx_write_en (tx_write_en),
        .tx_data     (max_index),      // held by the correlator until next start
        .tx_ready    (tx_ready),
        .rs_tx       (rs_tx)
    );

endmodule

`default_nettype wire

// File: hw/uart_tx.sv
// 8N1 uart transmitter, lsb first, ready while idle
`timescale 1ns/1ps
`default_nettype none

`include "sonar_consts.svh"

module uart_tx (
    input  wire logic                  clk,
    input  wire logic                  reset_b,
    input  wire logic                  tx_write_en,
    input  wire sonar_data_pkg::lag_t  tx_data,
    output logic                       tx_ready,
    output logic                       rs_tx
);
    import sonar_data_pkg::*;
    import sonar_ctrl_pkg::*;

    localparam int baud_w = $clog2(`SONAR_BAUD_DIV);

    uart_state_t       state;
    logic [baud_w-1:0] baud_cnt;
    logic [2:0]        bit_cnt;
    lag_t              shreg;
    logic              bit_end;

    assign bit_end  = (baud_cnt == baud_w'(`SONAR_BAUD_DIV - 1));
    assign tx_ready = (state == uart_idle);

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            state    <= uart_idle;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            shreg    <= '0;
            rs_tx    <= 1'b1;              // line idles high
        end else begin
            baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
            case (state)
                uart_idle: begin
                    baud_cnt <= '0;
                    if (tx_write_en) begin
                        shreg <= tx_data;  // latch byte
                        rs_tx <= 1'b0;     // start bit
                        state <= uart_start;
                    end
                end
                uart_start: if (bit_end) begin
                    rs_tx   <= shreg[0];
                    shreg   <= shreg >> 1;
                    bit_cnt <= '0;
                    state   <= uart_data;
                end
                uart_data: if (bit_end) begin
                    if (bit_cnt == 3'd7) begin
                        rs_tx <= 1'b1;     // stop bit
                        state <= uart_stop;
                    end else begin
                        rs_tx   <= shreg[0];
                        shreg   <= shreg >> 1;
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                uart_stop: if (bit_end) state <= uart_idle;
                default: state <= uart_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/cross_correlator.sv
// sliding +/-1 template correlation over the frozen window,
// keeps the lag with the largest sum (first lag wins ties)
`timescale 1ns/1ps
`default_nettype none

`include "sonar_consts.svh"

module cross_correlator (
    input  wire logic                      clk,
    input  wire logic                      reset_b,
    input  wire logic                      start_cc,
    output sonar_data_pkg::buf_off_t       rd_off,
    input  wire sonar_data_pkg::sample_t   rd_data,
    output logic                           cc_done,
    output sonar_data_pkg::lag_t           max_index
);
    import sonar_data_pkg::*;

    localparam int lag_w = $clog2(`SONAR_LAGS);
    localparam int tap_w = $clog2(`SONAR_TAPS);
    localparam logic [`SONAR_TAPS-1:0] tmpl = `SONAR_TEMPLATE;
    localparam acc_t acc_min = {1'b1, {($bits(acc_t)-1){1'b0}}};

    logic             running;
    logic [lag_w-1:0] lag_cnt;
    logic [tap_w-1:0] tap_cnt;
    logic             last_tap, last_lag;
    acc_t             acc, term, acc_next;
    acc_t             lag_sum, best_sum;
    logic [lag_w-1:0] sum_lag;             // lag that lag_sum belongs to
    logic             sum_valid, sum_last;

    assign last_tap = (tap_cnt == tap_w'(`SONAR_TAPS - 1));
    assign last_lag = (lag_cnt == lag_w'(`SONAR_LAGS - 1));

    // window sample for this (lag, tap)
    assign rd_off = buf_off_t'(lag_cnt) + buf_off_t'(tap_cnt);

    always_comb begin
        term     = tmpl[tap_cnt] ? acc_t'(rd_data) : -acc_t'(rd_data);
        acc_next = acc + term;
    end

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            running   <= 1'b0;
            lag_cnt   <= '0;
            tap_cnt   <= '0;
            acc       <= '0;
            lag_sum   <= '0;
            sum_lag   <= '0;
            sum_valid <= 1'b0;
            sum_last  <= 1'b0;
            best_sum  <= acc_min;
            max_index <= '0;
            cc_done   <= 1'b0;
        end else begin
            sum_valid <= 1'b0;
            cc_done   <= 1'b0;

            // compare stage, overlaps next lag's accumulation
            if (sum_valid) begin
                if (lag_sum > best_sum) begin      // strict, lowest lag kept on tie
                    best_sum  <= lag_sum;
                    max_index <= lag_t'(sum_lag);
                end
                cc_done <= sum_last;
            end

            if (start_cc) begin
                running   <= 1'b1;
                lag_cnt   <= '0;
                tap_cnt   <= '0;
                acc       <= '0;
                best_sum  <= acc_min;
                max_index <= '0;
            end else if (running) begin
                if (last_tap) begin
                    lag_sum   <= acc_next;         // full sum for this lag
                    sum_lag   <= lag_cnt;
                    sum_valid <= 1'b1;
                    sum_last  <= last_lag;
                    acc       <= '0;
                    tap_cnt   <= '0;
                    lag_cnt   <= lag_cnt + 1'b1;
                    if (last_lag) running <= 1'b0;
                end else begin
                    acc     <= acc_next;
                    tap_cnt <= tap_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/sample_ring_buffer.sv
// four-phase sample intake into a circular store, threshold trigger,
// read port addressed back from the last written sample
`timescale 1ns/1ps
`default_nettype none

`include "sonar_consts.svh"

module sample_ring_buffer (
    input  wire logic                      clk,
    input  wire logic                      reset_b,
    input  wire logic                      sample_req,
    input  wire sonar_data_pkg::sample_t   sample_data,
    output logic                           sample_ack,
    input  wire logic                      spi_en,      // low freezes the store
    output logic                           trigger,
    input  wire sonar_data_pkg::buf_off_t  rd_off,
    output sonar_data_pkg::sample_t        rd_data
);
    import sonar_data_pkg::*;

    sample_t  mem [`SONAR_BUF_DEPTH];
    buf_off_t last_addr;                   // address of newest sample
    logic     accept;
    logic [`SONAR_SAMPLE_W-1:0] mag;       // unsigned, -2048 fits as 2048
    logic     hit;

    // new request, not yet acked, intake armed
    assign accept = sample_req && !sample_ack && spi_en;

    assign mag = (sample_data < 0) ? -sample_data : sample_data;
    assign hit = (mag >= `SONAR_TRIG_LEVEL);

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            sample_ack <= 1'b0;
            trigger    <= 1'b0;
            last_addr  <= '1;              // first write lands at 0
        end else begin
            trigger <= 1'b0;
            if (accept) begin
                sample_ack <= 1'b1;
                last_addr  <= last_addr + 1'b1;
                trigger    <= hit;         // rises with the ack
            end else if (!sample_req) begin
                sample_ack <= 1'b0;        // return to zero phase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) mem[last_addr + 1'b1] <= sample_data;
    end

    // offset 0 is the newest sample, wraps mod depth
    assign rd_data = mem[last_addr - rd_off];

endmodule

`default_nettype wire

// File: hw/pipeline_controller.sv
// sequencer for trigger -> correlation -> uart report -> hold-off
// hold-off counted by an internal general counter
`timescale 1ns/1ps
`default_nettype none

`include "sonar_consts.svh"

module pipeline_controller (
    input  wire logic clk,
    input  wire logic reset_b,
    input  wire logic trigger,            // one-cycle pulse from the ring buffer
    input  wire logic cc_done,            // correlator finished
    input  wire logic tx_ready,           // uart idle
    input  wire logic rs_tx,              // line watched for the start bit
    output logic      trigger_persistent, // busy while a capture is in flight
    output logic      start_cc,
    output logic      tx_write_en,
    output logic      spi_en              // sample intake armed
);
    import sonar_ctrl_pkg::*;

    ctrl_state_t state, next_state;
    count_sel_t  count_sel;
    logic        holdoff_done;

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            state <= ctrl_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        // defaults, overridden per state
        trigger_persistent = 1'b0;
        start_cc           = 1'b0;
        tx_write_en        = 1'b0;
        spi_en             = 1'b0;
        count_sel          = cnt_zero;
        next_state         = state;

        case (state)
            ctrl_idle: begin
                spi_en = 1'b1;                    // armed, buffer acks samples
                if (trigger) next_state = ctrl_triggered;
            end
            ctrl_triggered: begin
                trigger_persistent = 1'b1;
                start_cc           = 1'b1;        // single cycle kick
                next_state         = ctrl_wait_cc;
            end
            ctrl_wait_cc: begin
                trigger_persistent = 1'b1;
                if (cc_done) next_state = ctrl_wait_tx;
            end
            ctrl_wait_tx: begin
                // correlator keeps max_index, nothing to latch here
                trigger_persistent = 1'b1;
                if (tx_ready) next_state = ctrl_tx_start;
            end
            ctrl_tx_start: begin
                trigger_persistent = 1'b1;
                tx_write_en        = 1'b1;        // held until start bit seen
                if (!rs_tx) next_state = ctrl_holdoff;
            end
            ctrl_holdoff: begin
                count_sel = cnt_count;            // still disarmed
                if (holdoff_done) next_state = ctrl_idle;
            end
            default: begin
                spi_en     = 1'b1;
                next_state = ctrl_idle;
            end
        endcase
    end

    // hold-off in clk cycles
    general_counter #(
        .count_val (`SONAR_HOLDOFF)
    ) i_holdoff_cnt (
        .clk           (clk),
        .reset_b       (reset_b),
        .count_sel     (count_sel),
        .count_reached (holdoff_done)
    );

endmodule

`default_nettype wire

// File: hw/general_counter.sv
// terminal counter with zero / hold / count selects
`timescale 1ns/1ps
`default_nettype none

module general_counter #(
    parameter int unsigned count_val = 16   // terminal value
) (
    input  wire logic                       clk,
    input  wire logic                       reset_b,
    input  wire sonar_ctrl_pkg::count_sel_t count_sel,
    output logic                            count_reached
);
    import sonar_ctrl_pkg::*;

    localparam int cnt_w = $clog2(count_val + 1);

    logic [cnt_w-1:0] count;

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            count <= '0;
        end else begin
            case (count_sel)
                cnt_zero:  count <= '0;
                cnt_count: if (!count_reached) count <= count + 1'b1; // saturates at terminal
                default:   count <= count;                            // hold
            endcase
        end
    end

    assign count_reached = (count == cnt_w'(count_val));

endmodule

`default_nettype wire

// File: hw/sonar_ctrl_pkg.sv
// state enums for the pipeline controller and uart transmitter
// and the general counter select
`default_nettype none

package sonar_ctrl_pkg;

    typedef enum logic [2:0] {
        ctrl_idle, ctrl_triggered, ctrl_wait_cc, ctrl_wait_tx, ctrl_tx_start, ctrl_holdoff
    } ctrl_state_t;

    typedef enum logic [1:0] {uart_idle, uart_start, uart_data, uart_stop} uart_state_t;

    // select codes for the general counter
    typedef enum logic [1:0] {cnt_zero = 2'b00, cnt_hold = 2'b10, cnt_count = 2'b11} count_sel_t;

endpackage

`default_nettype wire

// File: hw/sonar_data_pkg.sv
// datapath types: samples, correlation sums, buffer offsets, lag index
`default_nettype none

package sonar_data_pkg;

    `include "sonar_consts.svh"

    // one signed sample as delivered by the front end
    typedef logic signed [`SONAR_SAMPLE_W-1:0] sample_t;

    // correlation sum, 3 extra bits for 8 taps
    typedef logic signed [`SONAR_SAMPLE_W+2:0] acc_t;

    // offset back from the trigger sample, also the ring address
    typedef logic [4:0] buf_off_t;

    // lag index, sent as the uart byte
    typedef logic [7:0] lag_t;

endpackage

`default_nettype wire

// File: hw/sonar_consts.svh
// sonar receiver sizes, trigger threshold, template,
// uart bit length and hold-off length
`ifndef SONAR_CONSTS_SVH
`define SONAR_CONSTS_SVH

`define SONAR_SAMPLE_W   12          // signed sample width
`define SONAR_BUF_DEPTH  32          // power of two, ring wraps on pointer overflow
`define SONAR_TAPS       8           // template length
`define SONAR_LAGS       16          // lags searched from the trigger sample back

// bit k set -> tap k weighted +1, clear -> -1
`define SONAR_TEMPLATE   8'b1110_0010

`define SONAR_TRIG_LEVEL 1000        // magnitude that fires a capture
`define SONAR_BAUD_DIV   4           // clk cycles per uart bit, short for sim
`define SONAR_HOLDOFF    64          // disarmed clk cycles after a report

`endif
